/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := wb_subsys_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+include
rtl/wb_bus_pkg.sv
rtl/wb_addr_decoder.sv
rtl/wb_reg_unit.sv
rtl/wb_resp_router.sv
rtl/wb_subsys_top.sv
test/wb_subsys_assert.sv
test/wb_subsys_tb.sv

/* include/wb_bus_macros.svh */
`ifndef WB_BUS_MACROS_SVH
`define WB_BUS_MACROS_SVH

//--------------------------------------------------------------------------
// Bus geometry
//--------------------------------------------------------------------------
`define WB_ADR_W     7   // Master address width
`define WB_DAT_W     8   // Data byte width

// Slot decode takes the address MSBs
`define WB_DEC_BITS  3   // 8 slots, 4 of them mapped

//--------------------------------------------------------------------------
// Register units
//--------------------------------------------------------------------------
`define WB_NUM_UNITS 4   // Mapped at slots 0..3
`define WB_UNIT_REGS 4   // Last one is the status register

`endif

/* rtl/wb_addr_decoder.sv */
`default_nettype none

`include "wb_bus_macros.svh"

module wb_addr_decoder
   import wb_bus_pkg::*;
(
   input  wire                     bus_clk_i,
   input  wire                     rst_n_i,
   // Master request
   input  wire                     cyc_i,
   input  wire                     stb_i,
   input  wire                     we_i,
   input  wb_adr_t                 adr_i,
   input  wb_dat_t                 dat_i,
   // Router handshake
   input  wire                     done_i,      // Reply went to the master
   // Unit side
   output unit_req_t               unit_req_o,
   output logic [`WB_NUM_UNITS-1:0] unit_stb_o,
   output logic                    issue_o,     // One pulse per request
   output slot_t                   sel_slot_o   // Held until the next request
);

   dec_state_t state;
   unit_req_t  req_r;     // Captured request
   slot_t      slot_r;    // Captured slot
   logic       req_valid;

   assign req_valid = cyc_i && stb_i;  // Single master, cyc only qualifies

   //-----------------------------------------------------------------------
   // FSM
   //-----------------------------------------------------------------------
   always_ff @(posedge bus_clk_i) begin
      if (!rst_n_i) begin
         state <= IDLE;
      end else begin
         unique case (state)
            IDLE:    if (req_valid) state <= ISSUE;
            ISSUE:   state <= WAIT;               // Strobe lasts one cycle
            WAIT:    if (done_i) state <= IDLE;   // stb_i ignored until here
            default: state <= IDLE;
         endcase
      end
   end

   // Capture request fields on acceptance
   always_ff @(posedge bus_clk_i) begin
      if (state == IDLE && req_valid) begin
         req_r.we      <= we_i;
         req_r.reg_adr <= adr_i[$bits(reg_adr_t)-1:0];    // Register in unit
         req_r.dat     <= dat_i;
         slot_r        <= adr_i[`WB_ADR_W-1 -: `WB_DEC_BITS]; // Top bits
      end
   end

   //-----------------------------------------------------------------------
   // Strobe to the addressed unit, none for slots 4..7
   //-----------------------------------------------------------------------
   always_comb begin
      unit_stb_o = '0;
      for (int i = 0; i < `WB_NUM_UNITS; i++) begin
         if (state == ISSUE && slot_r == slot_t'(i))
            unit_stb_o[i] = 1'b1;
      end
   end

   assign issue_o    = (state == ISSUE);  // Router tracks unmapped slots from this
   assign unit_req_o = req_r;             // Broadcast to every unit
   assign sel_slot_o = slot_r;

endmodule

`default_nettype wire

/* rtl/wb_bus_pkg.sv */
`default_nettype none

`include "wb_bus_macros.svh"

package wb_bus_pkg;

   //-----------------------------------------------------------------------
   // Vector types
   //-----------------------------------------------------------------------
   typedef logic [`WB_ADR_W-1:0]                 wb_adr_t;   // Master address
   typedef logic [`WB_DAT_W-1:0]                 wb_dat_t;   // Data byte
   typedef logic [`WB_DEC_BITS-1:0]              slot_t;     // Decoded slot
   typedef logic [$clog2(`WB_UNIT_REGS)-1:0]     reg_adr_t;  // Register in a unit

   //-----------------------------------------------------------------------
   // Decoder to unit request, shared by all units
   //-----------------------------------------------------------------------
   typedef struct packed {
      logic     we;       // Write when set
      reg_adr_t reg_adr;  // Register index
      wb_dat_t  dat;      // Write data
   } unit_req_t;

   // Unit response, one per unit
   typedef struct packed {
      logic    ack;  // Normal completion
      logic    err;  // Rejected access
      wb_dat_t dat;  // Read data
   } unit_rsp_t;

   //-----------------------------------------------------------------------
   // Decoder FSM
   //-----------------------------------------------------------------------
   typedef enum logic [1:0] {
      IDLE,   // Waiting for a request
      ISSUE,  // Strobe out to the unit
      WAIT    // Waiting for the router's reply
   } dec_state_t;

endpackage

`default_nettype wire

/* rtl/wb_reg_unit.sv */
`default_nettype none

`include "wb_bus_macros.svh"

module wb_reg_unit
   import wb_bus_pkg::*;
#(
   parameter int UNIT_IDX = 0  // Reported in the status upper nibble
) (
   input  wire       bus_clk_i,
   input  wire       rst_n_i,
   input  wire       stb_i,    // One-cycle strobe from the decoder
   input  unit_req_t req_i,
   output unit_rsp_t rsp_o     // Valid the cycle after the strobe
);

   localparam int       NIB_W    = `WB_DAT_W / 2;
   localparam int       NUM_RW   = `WB_UNIT_REGS - 1;          // R/W registers
   localparam reg_adr_t STAT_REG = reg_adr_t'(`WB_UNIT_REGS - 1);
   localparam logic [NIB_W-1:0] IDX_NIB = NIB_W'(UNIT_IDX);

   wb_dat_t          rw_regs [NUM_RW];
   logic [NIB_W-1:0] wr_cnt;       // Accepted writes, mod 16
   logic             ack_r;
   logic             err_r;
   wb_dat_t          dat_r;
   wb_dat_t          rd_dat;
   logic             is_stat;

   assign is_stat = (req_i.reg_adr == STAT_REG);

   // Read mux
   always_comb begin
      if (is_stat)
         rd_dat = {IDX_NIB, wr_cnt};     // Index | write count
      else
         rd_dat = rw_regs[req_i.reg_adr];
   end

   //-----------------------------------------------------------------------
   // Registers, counter and response flags
   //-----------------------------------------------------------------------
   always_ff @(posedge bus_clk_i) begin
      if (!rst_n_i) begin
         ack_r  <= 1'b0;
         err_r  <= 1'b0;
         wr_cnt <= '0;
         for (int i = 0; i < NUM_RW; i++)
            rw_regs[i] <= '0;              // Registers 0..2 start at zero
      end else begin
         ack_r <= 1'b0;                    // Pulses only
         err_r <= 1'b0;
         if (stb_i) begin
            if (req_i.we && is_stat) begin
               err_r <= 1'b1;              // Status is read-only
            end else begin
               ack_r <= 1'b1;
               if (req_i.we) begin
                  rw_regs[req_i.reg_adr] <= req_i.dat;
                  wr_cnt                 <= wr_cnt + 1'b1;  // Wraps at 16
               end
            end
         end
      end
   end

   // Read data, value before any write in the same access
   always_ff @(posedge bus_clk_i) begin
      if (stb_i) dat_r <= rd_dat;
   end

   always_comb begin
      rsp_o.ack = ack_r;
      rsp_o.err = err_r;
      rsp_o.dat = dat_r;
   end

endmodule

`default_nettype wire

/* rtl/wb_resp_router.sv */
`default_nettype none

`include "wb_bus_macros.svh"

module wb_resp_router
   import wb_bus_pkg::*;
(
   input  wire                           bus_clk_i,
   input  wire                           rst_n_i,
   input  unit_rsp_t [`WB_NUM_UNITS-1:0] unit_rsp_i,  // One per unit
   input  wire                           issue_i,     // Decoder strobe cycle
   input  slot_t                         sel_slot_i,  // Slot in flight
   // Master reply
   output logic                          ack_o,
   output logic                          err_o,
   output wb_dat_t                       dat_o,
   output logic                          done_o       // Frees the decoder
);

   unit_rsp_t rsp_sel;    // Response of the selected unit
   logic      mapped;
   logic      unmap_err;  // Unmapped issue, delayed one cycle
   logic      ack_r;
   logic      err_r;
   wb_dat_t   dat_r;

   assign mapped = (sel_slot_i < slot_t'(`WB_NUM_UNITS));

   //-----------------------------------------------------------------------
   // Response mux
   //-----------------------------------------------------------------------
   always_comb begin
      rsp_sel = '0;                        // Unmapped slot selects nothing
      for (int i = 0; i < `WB_NUM_UNITS; i++) begin
         if (sel_slot_i == slot_t'(i))
            rsp_sel = unit_rsp_i[i];
      end
   end

   // Unmapped err takes the same path length as a unit reply
   always_ff @(posedge bus_clk_i) begin
      if (!rst_n_i) unmap_err <= 1'b0;
      else          unmap_err <= issue_i && !mapped;
   end

   //-----------------------------------------------------------------------
   // Registered reply to the master
   //-----------------------------------------------------------------------
   always_ff @(posedge bus_clk_i) begin
      if (!rst_n_i) begin
         ack_r <= 1'b0;
         err_r <= 1'b0;
      end else begin
         ack_r <= rsp_sel.ack;
         err_r <= rsp_sel.err || unmap_err;
      end
   end

   // Data holds between acks
   always_ff @(posedge bus_clk_i) begin
      if (rsp_sel.ack) dat_r <= rsp_sel.dat;
   end

   assign ack_o  = ack_r;
   assign err_o  = err_r;
   assign dat_o  = dat_r;
   assign done_o = ack_r || err_r;  // Same cycle as the reply

endmodule

`default_nettype wire

/* rtl/wb_subsys_top.sv */
`default_nettype none

`include "wb_bus_macros.svh"

module wb_subsys_top
   import wb_bus_pkg::*;
(
   input  wire     bus_clk_i,
   input  wire     rst_n_i,
   // Master port, classic Wishbone
   input  wire     cyc_i,
   input  wire     stb_i,
   input  wire     we_i,
   input  wb_adr_t adr_i,
   input  wb_dat_t dat_i,
   output logic    ack_o,
   output logic    err_o,
   output wb_dat_t dat_o
);

   unit_req_t                     unit_req;
   logic [`WB_NUM_UNITS-1:0]      unit_stb;
   unit_rsp_t [`WB_NUM_UNITS-1:0] unit_rsp;
   logic                          issue;
   slot_t                         sel_slot;
   logic                          done;

   //-----------------------------------------------------------------------
   // Request path
   //-----------------------------------------------------------------------
   wb_addr_decoder i_decoder (
      .bus_clk_i  (bus_clk_i),
      .rst_n_i    (rst_n_i),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .dat_i      (dat_i),
      .done_i     (done),
      .unit_req_o (unit_req),
      .unit_stb_o (unit_stb),
      .issue_o    (issue),
      .sel_slot_o (sel_slot)
   );

   // Units at slots 0..3
   for (genvar g = 0; g < `WB_NUM_UNITS; g++) begin : g_unit
      wb_reg_unit #(
         .UNIT_IDX (g)
      ) i_unit (
         .bus_clk_i (bus_clk_i),
         .rst_n_i   (rst_n_i),
         .stb_i     (unit_stb[g]),
         .req_i     (unit_req),
         .rsp_o     (unit_rsp[g])
      );
   end

   //-----------------------------------------------------------------------
   // Response path
   //-----------------------------------------------------------------------
   wb_resp_router i_router (
      .bus_clk_i  (bus_clk_i),
      .rst_n_i    (rst_n_i),
      .unit_rsp_i (unit_rsp),
      .issue_i    (issue),
      .sel_slot_i (sel_slot),
      .ack_o      (ack_o),
      .err_o      (err_o),
      .dat_o      (dat_o),
      .done_o     (done)
   );

endmodule

`default_nettype wire

/* test/wb_subsys_assert.sv */
`default_nettype none

`include "wb_bus_macros.svh"

module wb_subsys_assert
   import wb_bus_pkg::*;
(
   input wire                     bus_clk_i,
   input wire                     rst_n_i,
   input wire                     cyc_i,
   input wire                     stb_i,
   input wire                     ack_i,
   input wire                     err_i,
   input wire [`WB_NUM_UNITS-1:0] unit_stb_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic busy;    // Accepted, reply not yet sampled
   logic accept;
   logic reply;

   assign reply  = ack_i || err_i;
   assign accept = cyc_i && stb_i && !busy;  // Mirrors decoder IDLE

   always_ff @(posedge bus_clk_i) begin
      if (!rst_n_i)    busy <= 1'b0;
      else if (accept) busy <= 1'b1;
      else if (reply)  busy <= 1'b0;  // Decoder back in IDLE after this edge
   end

   a_ack_err_excl: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      !(ack_i && err_i))
      else $error("ack_o and err_o high in the same cycle");

   // Capture, unit strobe, router reply
   a_latency: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      accept |=> !reply ##1 !reply ##1 reply)
      else $error("Reply not exactly 3 cycles after acceptance");

   a_reply_in_cycle: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      reply |-> cyc_i && stb_i)
      else $error("Reply without cyc and stb from the master");

   // At most one strobe, and only in the cycle right after acceptance
   a_stb_onehot: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      $onehot0(unit_stb_i) && (unit_stb_i == '0 || $past(accept)))
      else $error("Unit strobe not a single one-hot pulse after acceptance");

endmodule

bind wb_subsys_top wb_subsys_assert i_assert (
   .bus_clk_i  (bus_clk_i),
   .rst_n_i    (rst_n_i),
   .cyc_i      (cyc_i),
   .stb_i      (stb_i),
   .ack_i      (ack_o),
   .err_i      (err_o),
   .unit_stb_i (unit_stb)
);

`default_nettype wire

/* test/wb_subsys_tb.sv */
`default_nettype none

module wb_subsys_tb
   import wb_bus_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 20;  // Cycles to wait for ack or err

   logic    bus_clk;
   logic    rst_n;
   logic    cyc, stb, we;  // Master request controls
   wb_adr_t adr;
   wb_dat_t wdat;
   wb_dat_t rdat;
   logic    ack, err;

   wb_subsys_top i_dut (
      .bus_clk_i (bus_clk),
      .rst_n_i   (rst_n),
      .cyc_i     (cyc),
      .stb_i     (stb),
      .we_i      (we),
      .adr_i     (adr),
      .dat_i     (wdat),
      .ack_o     (ack),
      .err_o     (err),
      .dat_o     (rdat)
   );

   always #4 bus_clk = ~bus_clk;  // 8 ns period

   //--------------------------------------------------------------------------
   // Failure exit and compares
   //--------------------------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
      if (act !== exp)
         abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("Error: %s err expected %b actual %b", name, exp, act));
   endtask

   // One classic Wishbone cycle, stb held through the reply cycle
   task automatic do_transfer(input logic wr, input wb_adr_t a, input wb_dat_t d,
                              output logic got_err, output wb_dat_t got_dat);
      int waited;
      @(posedge bus_clk);
      #1;
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = wr;
      adr  = a;
      wdat = d;
      waited = 0;
      while (!(ack || err) && waited < TIMEOUT) begin
         @(posedge bus_clk);
         #1;                        // Registered outputs settled
         waited++;
      end
      if (!(ack || err))
         abort_run($sformatf("The DUT gave no reply at address %h within %0d cycles",
                             a, TIMEOUT));
      got_err = err;
      got_dat = rdat;
      @(posedge bus_clk);           // Reply seen, release next cycle
      #1;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   //--------------------------------------------------------------------------
   // Transfers from the data file
   //--------------------------------------------------------------------------
   initial begin
      int         fd;
      int         lineno;
      string      line;
      string      name;
      logic [7:0] op;         // W or R
      wb_adr_t    a;
      wb_dat_t    wd;
      wb_dat_t    exp_dat;
      logic       exp_err;
      logic       got_err;
      wb_dat_t    got_dat;
      bus_clk = 1'b0;
      rst_n   = 1'b0;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      wdat    = '0;
      lineno  = 0;
      fd = $fopen("test/wb_subsys_testdata.txt", "r");
      if (fd == 0)
         abort_run("Could not open test/wb_subsys_testdata.txt for reading");
      repeat (10) @(posedge bus_clk);  // Reset held 10 cycles
      #1;
      rst_n = 1'b1;
      while ($fgets(line, fd) != 0) begin
         lineno++;
         if (line.len() < 2 || line.getc(0) == "#")
            continue;                  // Column notes and blank lines
         if ($sscanf(line, "%s %h %h %h %h", op, a, wd, exp_dat, exp_err) != 5)
            abort_run($sformatf("Malformed test data on line %0d", lineno));
         name = $sformatf("line %0d %s %h", lineno, op, a);
         do_transfer(op == "W", a, wd, got_err, got_dat);
         check_err(name, exp_err, got_err);
         if (op == "R" && !exp_err)
            check_dat(name, exp_dat, got_dat);  // Read data only on ack
      end
      $fclose(fd);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* test/wb_subsys_testdata.txt */
# op adr wdat exp_rdat exp_err, all hex; adr[6:4] is the slot, adr[1:0] the register
# exp_rdat is compared only on reads that ack
R 00 00 00 0  # reset values
R 11 00 00 0
R 03 00 00 0  # unit 0 status
R 33 00 30 0  # unit 3 status
W 12 a5 00 0
R 12 00 a5 0
R 22 00 00 0  # unit 2 not aliased
R 13 00 11 0  # one write in unit 1
W 13 ff 00 1  # status is read-only
R 13 00 11 0
W 40 12 00 1  # unmapped slots
R 75 00 00 1
R 12 00 a5 0  # mapped again
W 10 01 00 0  # 15 more writes to unit 1
W 11 02 00 0
W 12 03 00 0
W 10 04 00 0
W 11 05 00 0
W 12 06 00 0
W 10 07 00 0
W 11 08 00 0
W 12 09 00 0
W 10 0a 00 0
W 11 0b 00 0
W 12 0c 00 0
W 10 0d 00 0
W 11 0e 00 0
W 12 0f 00 0
R 13 00 10 0  # count wrapped to zero
R 12 00 0f 0
